// ==== logic/mips_isa_pkg.sv ====
package mips_isa_pkg;

    localparam int INST_W = 32;

    // instruction field positions
    localparam int OPCODE_MSB = 31;
    localparam int OPCODE_LSB = 26;
    localparam int RS_MSB = 25;
    localparam int RS_LSB = 21;
    localparam int RT_MSB = 20;
    localparam int RT_LSB = 16;
    localparam int RD_MSB = 15;
    localparam int RD_LSB = 11;
    localparam int SHAMT_MSB = 10;
    localparam int SHAMT_LSB = 6;
    localparam int FUNCT_MSB = 5;
    localparam int FUNCT_LSB = 0;
    localparam int IMM_MSB = 15;
    localparam int IMM_LSB = 0;

    localparam int SHAMT_W = SHAMT_MSB - SHAMT_LSB + 1;
    localparam int FUNCT_W = FUNCT_MSB - FUNCT_LSB + 1;
    localparam int IMM_W = IMM_MSB - IMM_LSB + 1;

    // low bits that must be zero for a valid MFC0
    localparam int CP0_ZERO_MSB = 10;

    typedef enum logic [5:0] {
        OP_SPECIAL = 6'b000000,
        OP_REGIMM  = 6'b000001,
        OP_J       = 6'b000010,
        OP_JAL     = 6'b000011,
        OP_BEQ     = 6'b000100,
        OP_BNE     = 6'b000101,
        OP_BLEZ    = 6'b000110,
        OP_BGTZ    = 6'b000111,
        OP_ADDI    = 6'b001000,
        OP_ADDIU   = 6'b001001,
        OP_SLTI    = 6'b001010,
        OP_SLTIU   = 6'b001011,
        OP_ANDI    = 6'b001100,
        OP_ORI     = 6'b001101,
        OP_XORI    = 6'b001110,
        OP_LUI     = 6'b001111,
        OP_CP0     = 6'b010000,
        OP_LB      = 6'b100000,
        OP_LH      = 6'b100001,
        OP_LW      = 6'b100011,
        OP_LBU     = 6'b100100,
        OP_LHU     = 6'b100101,
        OP_SB      = 6'b101000,
        OP_SH      = 6'b101001,
        OP_SW      = 6'b101011
    } opcode_e;

    typedef enum logic [4:0] {
        REGIMM_BLTZ   = 5'b00000,
        REGIMM_BGEZ   = 5'b00001,
        REGIMM_BLTZAL = 5'b10000,
        REGIMM_BGEZAL = 5'b10001
    } regimm_e;

    typedef enum logic [5:0] {
        FUNCT_SLL  = 6'b000000,
        FUNCT_SRL  = 6'b000010,
        FUNCT_SRA  = 6'b000011,
        FUNCT_SLLV = 6'b000100,
        FUNCT_SRLV = 6'b000110,
        FUNCT_SRAV = 6'b000111,
        FUNCT_JR   = 6'b001000,
        FUNCT_JALR = 6'b001001,
        FUNCT_ADD  = 6'b100000,
        FUNCT_ADDU = 6'b100001,
        FUNCT_SUB  = 6'b100010,
        FUNCT_SUBU = 6'b100011,
        FUNCT_AND  = 6'b100100,
        FUNCT_OR   = 6'b100101,
        FUNCT_XOR  = 6'b100110,
        FUNCT_NOR  = 6'b100111,
        FUNCT_SLT  = 6'b101010,
        FUNCT_SLTU = 6'b101011
    } funct_e;

    typedef enum logic [4:0] {
        CP0_MFC0 = 5'b00000,
        CP0_MTC0 = 5'b00100
    } cp0_op_e;

    // operation handed to execute with NOP for anything not decoded
    typedef enum logic [5:0] {
        ALU_NOP = 6'd0,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLLV,
        ALU_SRLV,
        ALU_SRAV,
        ALU_JR,
        ALU_JALR,
        ALU_ADD,
        ALU_ADDU,
        ALU_SUB,
        ALU_SUBU,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_LUI,
        ALU_BEQ,
        ALU_BNE,
        ALU_BLEZ,
        ALU_BGTZ,
        ALU_BLTZ,
        ALU_BGEZ,
        ALU_BLTZAL,
        ALU_BGEZAL,
        ALU_J,
        ALU_JAL,
        ALU_LB,
        ALU_LH,
        ALU_LW,
        ALU_LBU,
        ALU_LHU,
        ALU_SB,
        ALU_SH,
        ALU_SW,
        ALU_CP0
    } alu_op_e;

endpackage

// ==== logic/core_cfg_pkg.sv ====
package core_cfg_pkg;

    localparam int DATA_W = 32;
    localparam int ADDR_W = 32;
    localparam int REG_IDX_W = 5;
    localparam int NUM_REGS = 32;

    // return address sits past the delay slot
    localparam int LINK_OFFSET = 8;

    // $ra
    localparam int RA_REG = 31;

endpackage

// ==== logic/regfile_if.sv ====
`timescale 1ns/1ps

interface regfile_if import core_cfg_pkg::*; ();

    logic                 rd_en_1;
    logic                 rd_en_2;
    logic [REG_IDX_W-1:0] rd_addr_1;
    logic [REG_IDX_W-1:0] rd_addr_2;
    logic [DATA_W-1:0]    rd_data_1;
    logic [DATA_W-1:0]    rd_data_2;

    modport decoder (
        output rd_en_1,
        output rd_en_2,
        output rd_addr_1,
        output rd_addr_2,
        input  rd_data_1,
        input  rd_data_2
    );

    modport storage (
        input  rd_en_1,
        input  rd_en_2,
        input  rd_addr_1,
        input  rd_addr_2,
        output rd_data_1,
        output rd_data_2
    );

endinterface

// ==== logic/funct_gen.sv ====
`timescale 1ns/1ps

module funct_gen
    import core_cfg_pkg::*;
    import mips_isa_pkg::*;
(
    input  opcode_e               op,
    input  logic [FUNCT_W-1:0]    funct_field,
    input  logic [REG_IDX_W-1:0]  rt_field,
    output alu_op_e               alu_op
);

    always_comb begin
        case (op)
            OP_SPECIAL: begin
                case (funct_field)
                    FUNCT_SLL:  alu_op = ALU_SLL;
                    FUNCT_SRL:  alu_op = ALU_SRL;
                    FUNCT_SRA:  alu_op = ALU_SRA;
                    FUNCT_SLLV: alu_op = ALU_SLLV;
                    FUNCT_SRLV: alu_op = ALU_SRLV;
                    FUNCT_SRAV: alu_op = ALU_SRAV;
                    FUNCT_JR:   alu_op = ALU_JR;
                    FUNCT_JALR: alu_op = ALU_JALR;
                    FUNCT_ADD:  alu_op = ALU_ADD;
                    FUNCT_ADDU: alu_op = ALU_ADDU;
                    FUNCT_SUB:  alu_op = ALU_SUB;
                    FUNCT_SUBU: alu_op = ALU_SUBU;
                    FUNCT_AND:  alu_op = ALU_AND;
                    FUNCT_OR:   alu_op = ALU_OR;
                    FUNCT_XOR:  alu_op = ALU_XOR;
                    FUNCT_NOR:  alu_op = ALU_NOR;
                    FUNCT_SLT:  alu_op = ALU_SLT;
                    FUNCT_SLTU: alu_op = ALU_SLTU;
                    default:    alu_op = ALU_NOP;
                endcase
            end
            OP_REGIMM: begin
                // branch kind lives in the rt field
                case (rt_field)
                    REGIMM_BLTZ:   alu_op = ALU_BLTZ;
                    REGIMM_BGEZ:   alu_op = ALU_BGEZ;
                    REGIMM_BLTZAL: alu_op = ALU_BLTZAL;
                    REGIMM_BGEZAL: alu_op = ALU_BGEZAL;
                    default:       alu_op = ALU_NOP;
                endcase
            end
            // immediate forms share the register ops
            OP_ADDI:  alu_op = ALU_ADD;
            OP_ADDIU: alu_op = ALU_ADDU;
            OP_SLTI:  alu_op = ALU_SLT;
            OP_SLTIU: alu_op = ALU_SLTU;
            OP_ANDI:  alu_op = ALU_AND;
            OP_ORI:   alu_op = ALU_OR;
            OP_XORI:  alu_op = ALU_XOR;
            OP_LUI:   alu_op = ALU_LUI;
            OP_BEQ:   alu_op = ALU_BEQ;
            OP_BNE:   alu_op = ALU_BNE;
            OP_BLEZ:  alu_op = ALU_BLEZ;
            OP_BGTZ:  alu_op = ALU_BGTZ;
            OP_J:     alu_op = ALU_J;
            OP_JAL:   alu_op = ALU_JAL;
            OP_LB:    alu_op = ALU_LB;
            OP_LH:    alu_op = ALU_LH;
            OP_LW:    alu_op = ALU_LW;
            OP_LBU:   alu_op = ALU_LBU;
            OP_LHU:   alu_op = ALU_LHU;
            OP_SB:    alu_op = ALU_SB;
            OP_SH:    alu_op = ALU_SH;
            OP_SW:    alu_op = ALU_SW;
            OP_CP0:   alu_op = ALU_CP0;
            default:  alu_op = ALU_NOP;
        endcase
    end

endmodule

// ==== logic/reg_file.sv ====
`timescale 1ns/1ps

module reg_file
    import core_cfg_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    regfile_if.storage           rf,
    input  logic                 wb_en,
    input  logic [REG_IDX_W-1:0] wb_addr,
    input  logic [DATA_W-1:0]    wb_data
);

    logic [DATA_W-1:0] regs [NUM_REGS];

    // zero reg first, then bypass from write-back, then storage
    function automatic logic [DATA_W-1:0] read_port(
        input logic                 en,
        input logic [REG_IDX_W-1:0] idx
    );
        logic [DATA_W-1:0] val;
        if (!en || idx == '0) begin
            val = '0;
        end else if (wb_en && wb_addr == idx) begin
            val = wb_data;
        end else begin
            val = regs[idx];
        end
        return val;
    endfunction

    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en && wb_addr != '0) begin
            regs[wb_addr] <= wb_data;
        end
    end

    always_comb begin
        rf.rd_data_1 = read_port(rf.rd_en_1, rf.rd_addr_1);
    end

    always_comb begin
        rf.rd_data_2 = read_port(rf.rd_en_2, rf.rd_addr_2);
    end

endmodule

// ==== logic/id_stage.sv ====
`timescale 1ns/1ps

module id_stage
    import core_cfg_pkg::*;
    import mips_isa_pkg::*;
(
    input  logic [ADDR_W-1:0]    addr,
    input  logic [INST_W-1:0]    inst,
    regfile_if.decoder           rf,
    output alu_op_e              alu_op,
    output logic [SHAMT_W-1:0]   shamt,
    output logic [DATA_W-1:0]    operand_1,
    output logic [DATA_W-1:0]    operand_2,
    output logic                 write_reg_en,
    output logic [REG_IDX_W-1:0] write_reg_addr
);

    opcode_e              op;
    logic [REG_IDX_W-1:0] rs;
    logic [REG_IDX_W-1:0] rt;
    logic [REG_IDX_W-1:0] rd;
    logic [IMM_W-1:0]     imm;
    logic [ADDR_W-1:0]    link_addr;
    logic                 regimm_known;
    logic                 regimm_link;
    logic                 is_link;
    logic                 mfc0_ok;

    assign op = opcode_e'(inst[OPCODE_MSB:OPCODE_LSB]);
    assign rs = inst[RS_MSB:RS_LSB];
    assign rt = inst[RT_MSB:RT_LSB];
    assign rd = inst[RD_MSB:RD_LSB];
    assign imm = inst[IMM_MSB:IMM_LSB];
    assign shamt = inst[SHAMT_MSB:SHAMT_LSB];

    assign link_addr = addr + ADDR_W'(LINK_OFFSET);

    assign regimm_known = rt inside {REGIMM_BLTZ, REGIMM_BGEZ, REGIMM_BLTZAL, REGIMM_BGEZAL};
    assign regimm_link = rt inside {REGIMM_BLTZAL, REGIMM_BGEZAL};

    // MFC0 needs the low eleven bits clear
    assign mfc0_ok = (rs == CP0_MFC0) && (inst[CP0_ZERO_MSB:0] == '0);

    funct_gen u_funct_gen (
        .op          (op),
        .funct_field (inst[FUNCT_MSB:FUNCT_LSB]),
        .rt_field    (rt),
        .alu_op      (alu_op)
    );

    // linking instructions carry the return address in operand 1
    always_comb begin
        case (op)
            OP_JAL:     is_link = 1'b1;
            OP_SPECIAL: is_link = (alu_op == ALU_JALR);
            OP_REGIMM:  is_link = regimm_link;
            default:    is_link = 1'b0;
        endcase
    end

    // register read requests
    always_comb begin
        rf.rd_en_1 = 1'b0;
        rf.rd_en_2 = 1'b0;
        rf.rd_addr_1 = '0;
        rf.rd_addr_2 = '0;
        case (op)
            OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI,
            OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU: begin
                rf.rd_en_1 = 1'b1;
                rf.rd_addr_1 = rs;
            end
            OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ,
            OP_SB, OP_SH, OP_SW, OP_SPECIAL: begin
                rf.rd_en_1 = 1'b1;
                rf.rd_en_2 = 1'b1;
                rf.rd_addr_1 = rs;
                rf.rd_addr_2 = rt;
            end
            OP_REGIMM: begin
                rf.rd_en_1 = regimm_known;
                rf.rd_addr_1 = regimm_known ? rs : '0;
            end
            OP_CP0: begin
                // MTC0 moves rt out to the coprocessor
                if (rs == CP0_MTC0) begin
                    rf.rd_en_1 = 1'b1;
                    rf.rd_addr_1 = rt;
                end
            end
            default: begin
            end
        endcase
    end

    always_comb begin
        if (is_link) begin
            operand_1 = link_addr;
        end else if (rf.rd_en_1) begin
            operand_1 = rf.rd_data_1;
        end else begin
            operand_1 = '0;
        end
    end

    always_comb begin
        case (op)
            OP_ANDI, OP_ORI, OP_XORI: begin
                operand_2 = {{(DATA_W-IMM_W){1'b0}}, imm};
            end
            OP_LUI: begin
                operand_2 = {imm, {(DATA_W-IMM_W){1'b0}}};
            end
            OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU,
            OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU,
            OP_SB, OP_SH, OP_SW: begin
                operand_2 = {{(DATA_W-IMM_W){imm[IMM_W-1]}}, imm};
            end
            OP_SPECIAL: begin
                operand_2 = rf.rd_data_2;
            end
            default: begin
                operand_2 = '0;
            end
        endcase
    end

    // write-back destination
    always_comb begin
        write_reg_en = 1'b0;
        write_reg_addr = '0;
        case (op)
            OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI,
            OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU: begin
                write_reg_en = 1'b1;
                write_reg_addr = rt;
            end
            OP_SPECIAL: begin
                if (alu_op != ALU_NOP) begin
                    write_reg_en = 1'b1;
                    write_reg_addr = rd;
                end
            end
            OP_JAL: begin
                write_reg_en = 1'b1;
                write_reg_addr = REG_IDX_W'(RA_REG);
            end
            OP_REGIMM: begin
                if (regimm_link) begin
                    write_reg_en = 1'b1;
                    write_reg_addr = REG_IDX_W'(RA_REG);
                end
            end
            OP_CP0: begin
                if (mfc0_ok) begin
                    write_reg_en = 1'b1;
                    write_reg_addr = rt;
                end
            end
            default: begin
            end
        endcase
    end

endmodule

// ==== logic/id_ex_latch.sv ====
`timescale 1ns/1ps

module id_ex_latch
    import core_cfg_pkg::*;
    import mips_isa_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 in_valid,
    input  alu_op_e              alu_op,
    input  logic [SHAMT_W-1:0]   shamt,
    input  logic [DATA_W-1:0]    operand_1,
    input  logic [DATA_W-1:0]    operand_2,
    input  logic                 write_reg_en,
    input  logic [REG_IDX_W-1:0] write_reg_addr,
    output logic                 ex_valid,
    output alu_op_e              ex_alu_op,
    output logic [SHAMT_W-1:0]   ex_shamt,
    output logic [DATA_W-1:0]    ex_operand_1,
    output logic [DATA_W-1:0]    ex_operand_2,
    output logic                 ex_write_reg_en,
    output logic [REG_IDX_W-1:0] ex_write_reg_addr
);

    // nothing stalls so it loads every cycle
    always_ff @(posedge clk) begin
        if (!rst) begin
            ex_valid <= 1'b0;
            ex_alu_op <= ALU_NOP;
            ex_shamt <= '0;
            ex_operand_1 <= '0;
            ex_operand_2 <= '0;
            ex_write_reg_en <= 1'b0;
            ex_write_reg_addr <= '0;
        end else begin
            ex_valid <= in_valid;
            ex_alu_op <= alu_op;
            ex_shamt <= shamt;
            ex_operand_1 <= operand_1;
            ex_operand_2 <= operand_2;
            // a bubble must never write back
            ex_write_reg_en <= in_valid && write_reg_en;
            ex_write_reg_addr <= write_reg_addr;
        end
    end

endmodule

// ==== logic/decode_top.sv ====
`timescale 1ns/1ps

module decode_top
    import core_cfg_pkg::*;
    import mips_isa_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 in_valid,
    input  logic [ADDR_W-1:0]    addr,
    input  logic [INST_W-1:0]    inst,
    input  logic                 wb_en,
    input  logic [REG_IDX_W-1:0] wb_addr,
    input  logic [DATA_W-1:0]    wb_data,
    output logic                 ex_valid,
    output alu_op_e              ex_alu_op,
    output logic [SHAMT_W-1:0]   ex_shamt,
    output logic [DATA_W-1:0]    ex_operand_1,
    output logic [DATA_W-1:0]    ex_operand_2,
    output logic                 ex_write_reg_en,
    output logic [REG_IDX_W-1:0] ex_write_reg_addr
);

    regfile_if rf_bus ();

    alu_op_e              id_alu_op;
    logic [SHAMT_W-1:0]   id_shamt;
    logic [DATA_W-1:0]    id_operand_1;
    logic [DATA_W-1:0]    id_operand_2;
    logic                 id_write_reg_en;
    logic [REG_IDX_W-1:0] id_write_reg_addr;

    reg_file u_reg_file (
        .clk     (clk),
        .rst     (rst),
        .rf      (rf_bus.storage),
        .wb_en   (wb_en),
        .wb_addr (wb_addr),
        .wb_data (wb_data)
    );

    id_stage u_id_stage (
        .addr           (addr),
        .inst           (inst),
        .rf             (rf_bus.decoder),
        .alu_op         (id_alu_op),
        .shamt          (id_shamt),
        .operand_1      (id_operand_1),
        .operand_2      (id_operand_2),
        .write_reg_en   (id_write_reg_en),
        .write_reg_addr (id_write_reg_addr)
    );

    id_ex_latch u_id_ex_latch (
        .clk               (clk),
        .rst               (rst),
        .in_valid          (in_valid),
        .alu_op            (id_alu_op),
        .shamt             (id_shamt),
        .operand_1         (id_operand_1),
        .operand_2         (id_operand_2),
        .write_reg_en      (id_write_reg_en),
        .write_reg_addr    (id_write_reg_addr),
        .ex_valid          (ex_valid),
        .ex_alu_op         (ex_alu_op),
        .ex_shamt          (ex_shamt),
        .ex_operand_1      (ex_operand_1),
        .ex_operand_2      (ex_operand_2),
        .ex_write_reg_en   (ex_write_reg_en),
        .ex_write_reg_addr (ex_write_reg_addr)
    );

endmodule

// ==== test/decode_asserts.sv ====
`timescale 1ns/1ps

module decode_asserts
    import core_cfg_pkg::*;
    import mips_isa_pkg::*;
(
    input logic                 clk,
    input logic                 rst,
    input logic                 ex_valid,
    input logic                 ex_write_reg_en,
    input logic [REG_IDX_W-1:0] ex_write_reg_addr,
    input alu_op_e              ex_alu_op
);

    int fails = 0;

    reset_clears: assert property (@(posedge clk) !rst |=> !ex_valid && !ex_write_reg_en)
        else begin
            $error("ex_valid or ex_write_reg_en high after a reset edge");
            fails++;
        end

    wen_needs_valid: assert property (@(posedge clk) disable iff (!rst)
        ex_write_reg_en |-> ex_valid)
        else begin
            $error("ex_write_reg_en high without ex_valid");
            fails++;
        end

    jal_dest: assert property (@(posedge clk) disable iff (!rst)
        ex_alu_op == ALU_JAL |-> ex_write_reg_addr != '0)
        else begin
            $error("JAL result with write-back register zero");
            fails++;
        end

endmodule

bind decode_top decode_asserts u_decode_asserts (
    .clk               (clk),
    .rst               (rst),
    .ex_valid          (ex_valid),
    .ex_write_reg_en   (ex_write_reg_en),
    .ex_write_reg_addr (ex_write_reg_addr),
    .ex_alu_op         (ex_alu_op)
);

// ==== test/decode_checker.sv ====
`timescale 1ns/1ps

module decode_checker
    import core_cfg_pkg::*;
    import mips_isa_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 in_valid,
    input  logic [ADDR_W-1:0]    addr,
    input  logic [INST_W-1:0]    inst,
    input  logic                 wb_en,
    input  logic [REG_IDX_W-1:0] wb_addr,
    input  logic [DATA_W-1:0]    wb_data,
    input  logic                 ex_valid,
    input  alu_op_e              ex_alu_op,
    input  logic [SHAMT_W-1:0]   ex_shamt,
    input  logic [DATA_W-1:0]    ex_operand_1,
    input  logic [DATA_W-1:0]    ex_operand_2,
    input  logic                 ex_write_reg_en,
    input  logic [REG_IDX_W-1:0] ex_write_reg_addr,
    output int                   errors,
    output int                   checks
);

    logic [DATA_W-1:0]    shadow [NUM_REGS];
    logic                 have_exp;
    string                exp_name;
    logic                 exp_valid;
    logic [5:0]           exp_alu_op;
    logic [SHAMT_W-1:0]   exp_shamt;
    logic [DATA_W-1:0]    exp_op1;
    logic [DATA_W-1:0]    exp_op2;
    logic                 exp_wen;
    logic [REG_IDX_W-1:0] exp_waddr;

    initial begin
        have_exp = 1'b0;
        errors = 0;
        checks = 0;
    end

    // zero register, then same-cycle write, then shadow copy
    function automatic logic [DATA_W-1:0] reg_read(input logic [REG_IDX_W-1:0] idx);
        if (idx == '0) begin
            return '0;
        end
        if (wb_en && wb_addr == idx) begin
            return wb_data;
        end
        return shadow[idx];
    endfunction

    function automatic logic [5:0] ref_alu_op(
        input logic [5:0] op,
        input logic [5:0] fn,
        input logic [4:0] rt
    );
        case (op)
            OP_SPECIAL: begin
                case (fn)
                    FUNCT_SLL:  return ALU_SLL;
                    FUNCT_SRL:  return ALU_SRL;
                    FUNCT_SRA:  return ALU_SRA;
                    FUNCT_SLLV: return ALU_SLLV;
                    FUNCT_SRLV: return ALU_SRLV;
                    FUNCT_SRAV: return ALU_SRAV;
                    FUNCT_JR:   return ALU_JR;
                    FUNCT_JALR: return ALU_JALR;
                    FUNCT_ADD:  return ALU_ADD;
                    FUNCT_ADDU: return ALU_ADDU;
                    FUNCT_SUB:  return ALU_SUB;
                    FUNCT_SUBU: return ALU_SUBU;
                    FUNCT_AND:  return ALU_AND;
                    FUNCT_OR:   return ALU_OR;
                    FUNCT_XOR:  return ALU_XOR;
                    FUNCT_NOR:  return ALU_NOR;
                    FUNCT_SLT:  return ALU_SLT;
                    FUNCT_SLTU: return ALU_SLTU;
                    default:    return ALU_NOP;
                endcase
            end
            OP_REGIMM: begin
                case (rt)
                    REGIMM_BLTZ:   return ALU_BLTZ;
                    REGIMM_BGEZ:   return ALU_BGEZ;
                    REGIMM_BLTZAL: return ALU_BLTZAL;
                    REGIMM_BGEZAL: return ALU_BGEZAL;
                    default:       return ALU_NOP;
                endcase
            end
            OP_ADDI:  return ALU_ADD;
            OP_ADDIU: return ALU_ADDU;
            OP_SLTI:  return ALU_SLT;
            OP_SLTIU: return ALU_SLTU;
            OP_ANDI:  return ALU_AND;
            OP_ORI:   return ALU_OR;
            OP_XORI:  return ALU_XOR;
            OP_LUI:   return ALU_LUI;
            OP_BEQ:   return ALU_BEQ;
            OP_BNE:   return ALU_BNE;
            OP_BLEZ:  return ALU_BLEZ;
            OP_BGTZ:  return ALU_BGTZ;
            OP_J:     return ALU_J;
            OP_JAL:   return ALU_JAL;
            OP_LB:    return ALU_LB;
            OP_LH:    return ALU_LH;
            OP_LW:    return ALU_LW;
            OP_LBU:   return ALU_LBU;
            OP_LHU:   return ALU_LHU;
            OP_SB:    return ALU_SB;
            OP_SH:    return ALU_SH;
            OP_SW:    return ALU_SW;
            OP_CP0:   return ALU_CP0;
            default:  return ALU_NOP;
        endcase
    endfunction

    task automatic predict();
        logic [5:0]           op;
        logic [REG_IDX_W-1:0] rs;
        logic [REG_IDX_W-1:0] rt;
        logic [REG_IDX_W-1:0] rd;
        logic [DATA_W-1:0]    sext;
        logic [DATA_W-1:0]    link;
        logic                 known;
        op = inst[31:26];
        rs = inst[25:21];
        rt = inst[20:16];
        rd = inst[15:11];
        sext = {{16{inst[15]}}, inst[15:0]};
        link = addr + LINK_OFFSET;
        exp_valid = in_valid;
        exp_alu_op = ref_alu_op(op, inst[5:0], rt);
        exp_shamt = inst[10:6];
        exp_op1 = '0;
        exp_op2 = '0;
        exp_wen = 1'b0;
        exp_waddr = '0;
        known = (exp_alu_op != ALU_NOP);
        exp_name = known ? "decode" : "unknown";
        case (op)
            OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI: begin
                exp_name = "alu_imm";
                exp_op1 = reg_read(rs);
                // logical immediates are zero-extended
                exp_op2 = (op inside {OP_ANDI, OP_ORI, OP_XORI}) ? {16'b0, inst[15:0]} : sext;
                exp_wen = 1'b1;
                exp_waddr = rt;
            end
            OP_LUI: begin
                exp_name = "lui";
                exp_op2 = {inst[15:0], 16'b0};
                exp_wen = 1'b1;
                exp_waddr = rt;
            end
            OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU, OP_SB, OP_SH, OP_SW: begin
                exp_name = op[3] ? "store" : "load";
                exp_op1 = reg_read(rs);
                exp_op2 = sext;
                exp_wen = !op[3];
                exp_waddr = op[3] ? '0 : rt;
            end
            OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ: begin
                exp_name = "branch";
                exp_op1 = reg_read(rs);
            end
            OP_SPECIAL: begin
                if (exp_alu_op == ALU_JALR) begin
                    exp_name = "jalr";
                end else if (known) begin
                    exp_name = "rtype";
                end
                exp_op1 = (exp_alu_op == ALU_JALR) ? link : reg_read(rs);
                exp_op2 = reg_read(rt);
                exp_wen = known;
                exp_waddr = known ? rd : '0;
            end
            OP_REGIMM: begin
                if (rt == REGIMM_BLTZAL || rt == REGIMM_BGEZAL) begin
                    exp_name = "link_branch";
                    exp_op1 = link;
                    exp_wen = 1'b1;
                    exp_waddr = REG_IDX_W'(RA_REG);
                end else if (known) begin
                    exp_name = "regimm";
                    exp_op1 = reg_read(rs);
                end
            end
            OP_JAL: begin
                exp_name = "jal";
                exp_op1 = link;
                exp_wen = 1'b1;
                exp_waddr = REG_IDX_W'(RA_REG);
            end
            OP_CP0: begin
                exp_name = "cp0";
                if (rs == CP0_MTC0) begin
                    exp_op1 = reg_read(rt);
                end
                // MFC0 only with the low eleven bits clear
                if (rs == CP0_MFC0 && inst[10:0] == '0) begin
                    exp_wen = 1'b1;
                    exp_waddr = rt;
                end
            end
            default: begin
            end
        endcase
        exp_wen = exp_wen && in_valid;
    endtask

    task automatic check_field(
        input string             field,
        input logic [DATA_W-1:0] exp,
        input logic [DATA_W-1:0] act
    );
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Fail %s %s expected %h actual %h", exp_name, field, exp, act);
        end
    endtask

    // inputs sampled before the edge and outputs compared one edge later
    always @(posedge clk) begin
        if (have_exp) begin
            check_field("valid", exp_valid, ex_valid);
            check_field("alu_op", exp_alu_op, ex_alu_op);
            check_field("shamt", exp_shamt, ex_shamt);
            check_field("operand_1", exp_op1, ex_operand_1);
            check_field("operand_2", exp_op2, ex_operand_2);
            check_field("write_reg_en", exp_wen, ex_write_reg_en);
            check_field("write_reg_addr", exp_waddr, ex_write_reg_addr);
        end
        if (!rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                shadow[i] = '0;
            end
            exp_name = "reset";
            exp_valid = 1'b0;
            exp_alu_op = ALU_NOP;
            exp_shamt = '0;
            exp_op1 = '0;
            exp_op2 = '0;
            exp_wen = 1'b0;
            exp_waddr = '0;
        end else begin
            predict();
            if (wb_en && wb_addr != '0) begin
                shadow[wb_addr] = wb_data;
            end
        end
        have_exp = 1'b1;
    end

endmodule

// ==== test/tb_decode_top.sv ====
`timescale 1ns/1ps

module tb_decode_top
    import core_cfg_pkg::*;
    import mips_isa_pkg::*;
();

    logic                 clk = 1'b0;
    logic                 rst;
    logic                 in_valid;
    logic [ADDR_W-1:0]    addr;
    logic [INST_W-1:0]    inst;
    logic                 wb_en;
    logic [REG_IDX_W-1:0] wb_addr;
    logic [DATA_W-1:0]    wb_data;
    logic                 ex_valid;
    alu_op_e              ex_alu_op;
    logic [SHAMT_W-1:0]   ex_shamt;
    logic [DATA_W-1:0]    ex_operand_1;
    logic [DATA_W-1:0]    ex_operand_2;
    logic                 ex_write_reg_en;
    logic [REG_IDX_W-1:0] ex_write_reg_addr;

    int     errors;
    int     checks;
    int     timeouts;
    integer seed;

    always #50 clk = ~clk;

    decode_top i_dut (.*);

    decode_checker u_checker (.*);

    // mostly legal encodings with some raw opcodes, functs and rt codes mixed in
    function automatic logic [INST_W-1:0] make_inst();
        logic [INST_W-1:0] word;
        opcode_e           op;
        funct_e            fn;
        regimm_e           ri;
        int                k;
        word = $random(seed);
        op = op.first();
        k = {$random(seed)} % op.num();
        repeat (k) op = op.next();
        if ({$random(seed)} % 10 != 0) begin
            word[OPCODE_MSB:OPCODE_LSB] = op;
        end
        case (word[OPCODE_MSB:OPCODE_LSB])
            OP_SPECIAL: begin
                fn = fn.first();
                k = {$random(seed)} % fn.num();
                repeat (k) fn = fn.next();
                if ({$random(seed)} % 8 != 0) begin
                    word[FUNCT_MSB:FUNCT_LSB] = fn;
                end
            end
            OP_REGIMM: begin
                ri = ri.first();
                k = {$random(seed)} % ri.num();
                repeat (k) ri = ri.next();
                if ({$random(seed)} % 4 != 0) begin
                    word[RT_MSB:RT_LSB] = ri;
                end
            end
            OP_CP0: begin
                word[RS_MSB:RS_LSB] = ({$random(seed)} % 2 != 0) ? CP0_MTC0 : CP0_MFC0;
                if ({$random(seed)} % 2 != 0) begin
                    word[CP0_ZERO_MSB:0] = '0;
                end
            end
            default: begin
            end
        endcase
        return word;
    endfunction

    task automatic wait_idle(input string what, input int limit);
        int n;
        n = 0;
        while ((ex_valid !== 1'b0 || ex_write_reg_en !== 1'b0) && n < limit) begin
            @(posedge clk);
            n++;
        end
        if (ex_valid !== 1'b0 || ex_write_reg_en !== 1'b0) begin
            $display("timeout: ex outputs still active %0d cycles into the %s wait", limit, what);
            timeouts++;
        end
    endtask

    initial begin
        logic [INST_W-1:0] cur;
        seed = 32'hb5d6f452;
        timeouts = 0;
        rst = 1'b0;
        in_valid = 1'b0;
        addr = '0;
        inst = '0;
        wb_en = 1'b0;
        wb_addr = '0;
        wb_data = '0;
        repeat (16) @(posedge clk);
        rst <= 1'b1;
        wait_idle("reset", 10);
        // back-to-back instructions with write-back often aimed at the rs being read
        for (int n = 0; n < 3000; n++) begin
            @(posedge clk);
            cur = make_inst();
            inst <= cur;
            addr <= $random(seed) & 32'hffff_fffc;
            in_valid <= ({$random(seed)} % 8 != 0);
            wb_en <= ($random(seed) % 2 != 0);
            wb_addr <= ({$random(seed)} % 4 == 0) ? cur[RS_MSB:RS_LSB] : REG_IDX_W'($random(seed));
            wb_data <= $random(seed);
        end
        @(posedge clk);
        in_valid <= 1'b0;
        wb_en <= 1'b0;
        wait_idle("drain", 10);
        repeat (2) @(posedge clk);
        #1;
        $display("%0d checks, %0d mismatches, %0d timeouts, %0d assertion failures",
                 checks, errors, timeouts, i_dut.u_decode_asserts.fails);
        if (errors == 0 && timeouts == 0 && i_dut.u_decode_asserts.fails == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
logic/mips_isa_pkg.sv
logic/core_cfg_pkg.sv
logic/regfile_if.sv
logic/funct_gen.sv
logic/reg_file.sv
logic/id_stage.sv
logic/id_ex_latch.sv
logic/decode_top.sv
test/decode_asserts.sv
test/decode_checker.sv
test/tb_decode_top.sv
